/* Makefile */
# Verilator build and run of the core trace testbench.

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tb_ctm_top -f build.f -Mdir obj_dir -o sim_ctm

run: compile
	./obj_dir/sim_ctm | tee sim.log
	@if grep -q "Done: errors found" sim.log; then \
	  echo "simulation failed, see sim.log"; \
	  exit 1; \
	fi
	@grep -q "Done: no errors" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* build.f */
+incdir+verif
verilog/dbg_pkg.sv
verilog/dii_if.sv
verilog/ctm_reg_access.sv
verilog/trace_event_fifo.sv
verilog/trace_packetizer.sv
verilog/osd_ctm.sv
verilog/osd_ctm_mor1kx.sv
verilog/dbg_ctm_top.sv
verif/tb_ctm_top.sv

/* verif/tb_ctm_model.svh */
//##########################################################################
// core trace reference model
// decides which trace strobes become events and builds the expected flits
// of trace and overflow packets from the packet formats.
//##########################################################################

`ifndef TB_CTM_MODEL_SVH
`define TB_CTM_MODEL_SVH

// a strobe is kept when it is a jump and tracing is on.
function automatic bit event_kept(input logic valid, input logic jal, input logic jr,
                                  input logic en);
  return valid && en && (jal || jr);
endfunction

function automatic trace_event_t make_event(input logic [31:0] pc, input logic [31:0] target,
                                            input logic jr);
  trace_event_t ev;
  ev.pc   = pc;
  ev.npc  = target;  // the jump target is the next pc.
  ev.kind = jr;      // 1 for a register jump.
  return ev;
endfunction

// flit idx of the seven-flit trace packet.
function automatic logic [15:0] trace_flit(input logic [15:0] dest, input logic [15:0] src,
                                           input trace_event_t ev, input int idx);
  logic [15:0] word;
  case (idx)
    0:       word = dest;
    1:       word = src;
    2:       word = {TYPE_TRACE_EVENT[15:1], ev.kind};  // kind in bit 0.
    3:       word = ev.pc[31:16];
    4:       word = ev.pc[15:0];
    5:       word = ev.npc[31:16];
    default: word = ev.npc[15:0];
  endcase
  return word;
endfunction

// flit idx of the four-flit overflow packet.
function automatic logic [15:0] overflow_flit(input logic [15:0] dest, input logic [15:0] src,
                                              input logic [15:0] count, input int idx);
  logic [15:0] word;
  case (idx)
    0:       word = dest;
    1:       word = src;
    2:       word = TYPE_TRACE_OVERFLOW;
    default: word = count;
  endcase
  return word;
endfunction

`endif

/* verif/tb_ctm_top.sv */
//##########################################################################
// core trace testbench
// drives trace strobes and register writes into the core trace top level,
// applies back-pressure on the outgoing ring and checks each trace and
// overflow packet against the reference model.
//##########################################################################

module tb_ctm_top
  import dbg_pkg::*;
();

  localparam int          FIFO_DEPTH   = 4;
  localparam logic [15:0] DUT_ID       = 16'h00c3;
  localparam int          BURST_LEN    = 16;  // long enough to overflow the queue.
  localparam int          QUIET_CYCLES = 20;  // idle cycles that count as drained.
  localparam int          READY_HIGH   = 0;
  localparam int          READY_RANDOM = 1;
  localparam int          READY_LOW    = 2;

  logic        clk;
  logic        reset;
  logic [15:0] id;
  logic        debug_in_valid;
  logic        debug_in_last;
  logic [15:0] debug_in_data;
  logic        debug_in_ready;
  logic        debug_out_valid;
  logic        debug_out_last;
  logic [15:0] debug_out_data;
  logic        debug_out_ready;
  logic        trace_valid;
  logic [31:0] trace_pc;
  logic [31:0] trace_jbtarget;
  logic        trace_jal;
  logic        trace_jr;

  trace_event_t exp_q [$];     // events expected on the ring in arrival order.
  logic [15:0]  exp_dest;      // model of the destination register.
  logic         model_enable;  // model of the enable register.
  int           ready_mode;
  bit           drop_mode;     // overflow packets allowed.
  bit           ovf_seen;
  int           drop_total;
  int           delivered;
  int           error_count;
  int           rx_idx;        // flit index inside the current packet.
  bit           rx_ovf;
  bit           stalled;
  logic [17:0]  held_flit;

  `include "tb_ctm_model.svh"

  dbg_ctm_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dbg_ctm_top_inst (
    .clk             (clk),
    .reset           (reset),
    .id              (id),
    .debug_in_valid  (debug_in_valid),
    .debug_in_last   (debug_in_last),
    .debug_in_data   (debug_in_data),
    .debug_in_ready  (debug_in_ready),
    .debug_out_valid (debug_out_valid),
    .debug_out_last  (debug_out_last),
    .debug_out_data  (debug_out_data),
    .debug_out_ready (debug_out_ready),
    .trace_valid     (trace_valid),
    .trace_pc        (trace_pc),
    .trace_jbtarget  (trace_jbtarget),
    .trace_jal       (trace_jal),
    .trace_jr        (trace_jr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // period of 8.
  end

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    error_count++;
    $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    stop_with_failure();
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("ERROR at %0t: %s", $time, what);
    stop_with_failure();
  endtask

  task automatic send_in_flit(input logic [15:0] data, input logic last);
    @(negedge clk);
    debug_in_valid = 1'b1;
    debug_in_last  = last;
    debug_in_data  = data;
    // the register port never stalls the incoming ring.
    assert (debug_in_ready == 1'b1)
      else report_mismatch("debug_in_ready", 32'(debug_in_ready), 32'(1'b1));
  endtask

  task automatic end_in_packet();
    @(negedge clk);
    debug_in_valid = 1'b0;
    debug_in_last  = 1'b0;
  endtask

  // write packet of dest, source, address and value.
  task automatic write_reg(input logic [15:0] addr, input logic [15:0] value);
    send_in_flit(DUT_ID, 1'b0);
    send_in_flit(16'h0001, 1'b0);
    send_in_flit(addr, 1'b0);
    send_in_flit(value, 1'b1);
    end_in_packet();
    if (addr == REG_ENABLE) begin
      model_enable = value[0];
    end else if (addr == REG_EVENT_DEST) begin
      exp_dest = value;
    end
  endtask

  // packets that must leave both registers alone.
  task automatic send_bad_writes();
    send_in_flit(DUT_ID, 1'b0);  // five flits long.
    send_in_flit(16'h0001, 1'b0);
    send_in_flit(REG_EVENT_DEST, 1'b0);
    send_in_flit(16'hdead, 1'b0);
    send_in_flit(16'hdead, 1'b1);
    send_in_flit(DUT_ID, 1'b0);  // three flits without a value.
    send_in_flit(16'h0001, 1'b0);
    send_in_flit(REG_ENABLE, 1'b1);
    end_in_packet();
    write_reg(16'h0207, 16'hbeef);  // unknown address.
  endtask

  task automatic send_strobe(input logic valid, input logic jal, input logic jr);
    logic [31:0] pc;
    logic [31:0] target;
    pc     = $urandom() & 32'hffff_fffc;  // word aligned.
    target = $urandom() & 32'hffff_fffc;
    @(negedge clk);
    trace_valid    = valid;
    trace_pc       = pc;
    trace_jbtarget = target;
    trace_jal      = jal;
    trace_jr       = jr;
    if (event_kept(valid, jal, jr, model_enable)) begin
      exp_q.push_back(make_event(pc, target, jr));
    end
  endtask

  task automatic send_random_strobe();
    int   kind;
    logic valid;
    kind  = $urandom_range(0, 2);  // none, jal or jr.
    valid = ($urandom_range(0, 3) != 0);
    send_strobe(valid, kind == 1, kind == 2);
  endtask

  task automatic send_jump();
    logic jr;
    jr = ($urandom_range(0, 1) == 1);
    send_strobe(1'b1, !jr, jr);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      trace_valid = 1'b0;
      trace_jal   = 1'b0;
      trace_jr    = 1'b0;
    end
  endtask

  // drained when nothing is expected and the ring stays idle for a while.
  task automatic wait_quiet(input int timeout);
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    while (quiet < QUIET_CYCLES) begin
      @(negedge clk);
      cycles++;
      if (cycles > timeout) begin
        report_failure("timeout waiting for the trace output to drain");
      end else if (!debug_out_valid && (drop_mode || exp_q.size() == 0)) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
  endtask

  // ring sink that drives ready and checks every flit that moves.
  initial begin
    logic [15:0] exp_data;
    logic        exp_last;
    rx_idx          = 0;
    rx_ovf          = 1'b0;
    stalled         = 1'b0;
    held_flit       = '0;
    debug_out_ready = 1'b1;
    forever begin
      @(negedge clk);
      case (ready_mode)
        READY_HIGH:   debug_out_ready = 1'b1;
        READY_RANDOM: debug_out_ready = ($urandom_range(0, 1) == 1);
        default:      debug_out_ready = 1'b0;
      endcase
      if (stalled) begin
        assert ({debug_out_valid, debug_out_last, debug_out_data} == held_flit)
          else report_mismatch("stalled debug_out flit",
                               32'({debug_out_valid, debug_out_last, debug_out_data}),
                               32'(held_flit));
      end
      stalled   = debug_out_valid && !debug_out_ready;  // no transfer at next edge.
      held_flit = {debug_out_valid, debug_out_last, debug_out_data};
      if (debug_out_valid && debug_out_ready) begin
        if (drop_mode && rx_idx == 2) begin
          rx_ovf = (debug_out_data == TYPE_TRACE_OVERFLOW);
        end
        if (rx_ovf || (drop_mode && rx_idx < 2)) begin
          exp_data = overflow_flit(exp_dest, DUT_ID, debug_out_data, rx_idx);
          exp_last = (rx_idx == OVF_PKT_LEN - 1);
        end else begin
          assert (exp_q.size() != 0)
            else report_failure("trace packet arrived with no event expected");
          exp_data = trace_flit(exp_dest, DUT_ID, exp_q[0], rx_idx);
          exp_last = (rx_idx == TRACE_PKT_LEN - 1);
        end
        assert (debug_out_data == exp_data)
          else report_mismatch("debug_out_data", 32'(debug_out_data), 32'(exp_data));
        assert (debug_out_last == exp_last)
          else report_mismatch("debug_out_last", 32'(debug_out_last), 32'(exp_last));
        if (debug_out_last) begin
          if (rx_ovf) begin
            assert (debug_out_data != '0)
              else report_failure("overflow packet carried a zero drop count");
            drop_total += int'(debug_out_data);
            ovf_seen = 1'b1;
          end else begin
            // only the packet stalled when the drops began may precede the report.
            assert (!drop_mode || ovf_seen || delivered == 0)
              else report_failure("trace packet after the drops came before the overflow packet");
            void'(exp_q.pop_front());
            delivered++;
          end
          rx_idx = 0;
          rx_ovf = 1'b0;
        end else begin
          rx_idx++;
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h2669ca0d));
    reset          = 1'b1;
    id             = DUT_ID;
    debug_in_valid = 1'b0;
    debug_in_last  = 1'b0;
    debug_in_data  = '0;
    trace_valid    = 1'b0;
    trace_pc       = '0;
    trace_jbtarget = '0;
    trace_jal      = 1'b0;
    trace_jr       = 1'b0;
    exp_dest       = '0;
    model_enable   = 1'b0;
    ready_mode     = READY_HIGH;
    drop_mode      = 1'b0;
    ovf_seen       = 1'b0;
    drop_total     = 0;
    delivered      = 0;
    error_count    = 0;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    // tracing is off after reset.
    repeat (40) send_random_strobe();
    idle_cycles(1);
    wait_quiet(200);

    write_reg(REG_EVENT_DEST, 16'h1234);
    write_reg(REG_ENABLE, 16'h0001);
    send_bad_writes();
    send_strobe(1'b1, 1'b1, 1'b0);
    idle_cycles(8);
    send_strobe(1'b1, 1'b0, 1'b1);
    idle_cycles(8);
    wait_quiet(400);
    write_reg(REG_ENABLE, 16'hfffe);  // bit 0 clear turns tracing off.
    repeat (3) begin
      send_jump();
      idle_cycles(8);
    end
    wait_quiet(200);
    write_reg(REG_EVENT_DEST, 16'h5a01);
    write_reg(REG_ENABLE, 16'h8001);

    // spaced strobes with the ring always ready.
    repeat (24) begin
      send_random_strobe();
      idle_cycles(8);
    end
    wait_quiet(400);

    // bursts that fit the queue under random back-pressure.
    ready_mode = READY_RANDOM;
    repeat (6) begin
      repeat (FIFO_DEPTH) send_jump();
      idle_cycles(1);
      wait_quiet(2000);
    end

    // long burst into a stalled ring.
    ready_mode = READY_LOW;
    drop_mode  = 1'b1;
    drop_total = 0;
    delivered  = 0;
    ovf_seen   = 1'b0;
    idle_cycles(2);
    repeat (BURST_LEN) send_jump();
    idle_cycles(8);
    ready_mode = READY_HIGH;
    wait_quiet(2000);
    assert (drop_total > 0)
      else report_failure("stalled burst reported no dropped events");
    assert (delivered + drop_total == BURST_LEN)
      else report_mismatch("delivered plus dropped events", 32'(delivered + drop_total),
                           32'(BURST_LEN));
    exp_q.delete();  // the dropped tail.
    drop_mode = 1'b0;
    send_jump();
    idle_cycles(1);
    wait_quiet(400);

    if (error_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule

/* verilog/ctm_reg_access.sv */
//##########################################################################
// ctm register access
// parses four-flit write packets from the debug ring and holds the trace
// enable and the destination address of outgoing trace packets.
//##########################################################################

module ctm_reg_access
  import dbg_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  dii_if.receiver     debug_in,
  output logic        enable,
  output logic [15:0] event_dest
);

  logic [2:0]  flit_cnt;   // flits seen so far, saturates past a valid write.
  logic [15:0] reg_addr;   // address from the third flit.
  logic        flit_xfer;
  logic        write_hit;

  assign debug_in.ready = 1'b1;  // register writes never stall the ring.

  assign flit_xfer = debug_in.valid && debug_in.ready;
  // only a packet of exactly four flits carries a write.
  assign write_hit = flit_xfer && debug_in.last && (flit_cnt == 3'(REG_PKT_LEN - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      flit_cnt <= '0;
    end else if (flit_xfer) begin
      if (debug_in.last) begin
        flit_cnt <= '0;  // next flit starts a new packet.
      end else if (flit_cnt != 3'(REG_PKT_LEN)) begin
        flit_cnt <= flit_cnt + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (flit_xfer && (flit_cnt == 3'(REG_PKT_LEN - 2))) begin
      reg_addr <= debug_in.data;  // latch address flit.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      enable     <= 1'b0;
      event_dest <= '0;
    end else if (write_hit) begin
      case (reg_addr)
        REG_ENABLE:     enable     <= debug_in.data[0];
        REG_EVENT_DEST: event_dest <= debug_in.data;
        default:        ;  // unknown address, ignore.
      endcase
    end
  end

endmodule

/* verilog/dbg_ctm_top.sv */
//##########################################################################
// core trace top level
// bundles the trace pins and both debug ring links for the core trace
// adapter.
//##########################################################################

module dbg_ctm_top
  import dbg_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] id,
  input  logic        debug_in_valid,
  input  logic        debug_in_last,
  input  logic [15:0] debug_in_data,
  output logic        debug_in_ready,
  output logic        debug_out_valid,
  output logic        debug_out_last,
  output logic [15:0] debug_out_data,
  input  logic        debug_out_ready,
  input  logic        trace_valid,
  input  logic [31:0] trace_pc,
  input  logic [31:0] trace_jbtarget,
  input  logic        trace_jal,
  input  logic        trace_jr
);

  dii_if       debug_in_if ();   // incoming register writes.
  dii_if       debug_out_if ();  // outgoing trace packets.
  trace_exec_t trace_port;

  assign debug_in_if.valid = debug_in_valid;
  assign debug_in_if.last  = debug_in_last;
  assign debug_in_if.data  = debug_in_data;
  assign debug_in_ready    = debug_in_if.ready;

  assign debug_out_valid    = debug_out_if.valid;
  assign debug_out_last     = debug_out_if.last;
  assign debug_out_data     = debug_out_if.data;
  assign debug_out_if.ready = debug_out_ready;

  assign trace_port = '{
    valid:    trace_valid,
    pc:       trace_pc,
    jbtarget: trace_jbtarget,
    jal:      trace_jal,
    jr:       trace_jr
  };

  osd_ctm_mor1kx #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_ctm_mor1kx (
    .clk        (clk),
    .reset      (reset),
    .id         (id),
    .debug_in   (debug_in_if),
    .debug_out  (debug_out_if),
    .trace_port (trace_port)
  );

endmodule

/* verilog/dbg_pkg.sv */
//##########################################################################
// debug trace package
// flit, trace port and trace event types shared by the core trace module,
// plus the outgoing packet type codes and the configuration register map.
//##########################################################################

package dbg_pkg;

  // one debug ring flit.
  typedef struct packed {
    logic        valid;
    logic        last;
    logic [15:0] data;
  } dii_flit_t;

  // execution trace port of the core, one retired instruction per strobe.
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] jbtarget;  // jump or branch target.
    logic        jal;
    logic        jr;
  } trace_exec_t;

  // control-flow event as it sits in the queue.
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] npc;
    logic        kind;      // 0 = jal, 1 = jr.
  } trace_event_t;

  localparam logic KIND_JAL = 1'b0;
  localparam logic KIND_JR  = 1'b1;

  // type codes in the third flit, the event kind goes into bit 0.
  localparam logic [15:0] TYPE_TRACE_EVENT    = 16'h4000;
  localparam logic [15:0] TYPE_TRACE_OVERFLOW = 16'h4010;

  // configuration register addresses.
  localparam logic [15:0] REG_ENABLE     = 16'h0200;
  localparam logic [15:0] REG_EVENT_DEST = 16'h0201;

  // packet lengths in flits.
  localparam int REG_PKT_LEN   = 4;
  localparam int OVF_PKT_LEN   = 4;
  localparam int TRACE_PKT_LEN = 7;

endpackage

/* verilog/dii_if.sv */
//##########################################################################
// debug ring link
// one direction of the debug ring: valid, last and data from the sender,
// ready back from the receiver. a flit moves when valid and ready are high.
//##########################################################################

interface dii_if;

  logic        valid;  // flit present.
  logic        last;   // final flit of a packet.
  logic [15:0] data;
  logic        ready;  // receiver accepts the flit.

  modport sender (
    output valid,
    output last,
    output data,
    input  ready
  );

  modport receiver (
    input  valid,
    input  last,
    input  data,
    output ready
  );

endinterface

/* verilog/osd_ctm.sv */
//##########################################################################
// generic core trace module
// keeps jal and jr retirements while tracing is enabled, queues them and
// sends them as trace packets on the debug ring.
//##########################################################################

module osd_ctm
  import dbg_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] id,
  dii_if.receiver     debug_in,
  dii_if.sender       debug_out,
  input  logic        trace_valid,
  input  logic [31:0] trace_pc,
  input  logic [31:0] trace_npc,
  input  logic        trace_jal,
  input  logic        trace_jalr
);

  logic         enable;
  logic [15:0]  event_dest;
  logic         keep;        // strobe is a control-flow event to record.
  logic         ev_valid_q;
  trace_event_t ev_q;        // registered event stage.
  trace_event_t fifo_event;
  logic         fifo_empty;
  logic         fifo_pop;
  logic [15:0]  drop_count;
  logic         drop_clear;

  assign keep = trace_valid && enable && (trace_jal || trace_jalr);

  always_ff @(posedge clk) begin
    if (reset) begin
      ev_valid_q <= 1'b0;
    end else begin
      ev_valid_q <= keep;
    end
  end

  always_ff @(posedge clk) begin
    if (keep) begin
      ev_q <= '{pc: trace_pc, npc: trace_npc, kind: trace_jalr ? KIND_JR : KIND_JAL};
    end
  end

  ctm_reg_access u_reg_access (
    .clk        (clk),
    .reset      (reset),
    .debug_in   (debug_in),
    .enable     (enable),
    .event_dest (event_dest)
  );

  trace_event_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_event_fifo (
    .clk        (clk),
    .reset      (reset),
    .wr_en      (ev_valid_q),
    .wr_event   (ev_q),
    .rd_en      (fifo_pop),
    .rd_event   (fifo_event),
    .empty      (fifo_empty),
    .drop_count (drop_count),
    .drop_clear (drop_clear)
  );

  trace_packetizer u_packetizer (
    .clk        (clk),
    .reset      (reset),
    .id         (id),
    .event_dest (event_dest),
    .ev_empty   (fifo_empty),
    .ev         (fifo_event),
    .ev_pop     (fifo_pop),
    .drop_count (drop_count),
    .drop_clear (drop_clear),
    .debug_out  (debug_out)
  );

  // the core retires one instruction per strobe, never both jump kinds.
  a_one_jump: assert property (@(posedge clk) disable iff (reset)
    trace_valid |-> !(trace_jal && trace_jalr))
    else $error("jal and jalr set on one trace strobe.");

endmodule

/* verilog/osd_ctm_mor1kx.sv */
//##########################################################################
// core trace adapter
// maps the execution trace port of the core onto the generic trace
// inputs of the core trace module.
//##########################################################################

module osd_ctm_mor1kx
  import dbg_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] id,
  dii_if.receiver     debug_in,
  dii_if.sender       debug_out,
  input  trace_exec_t trace_port
);

  logic        trace_valid;
  logic [31:0] trace_pc;
  logic [31:0] trace_npc;
  logic        trace_jal;
  logic        trace_jalr;

  assign trace_valid = trace_port.valid;
  assign trace_pc    = trace_port.pc;
  assign trace_npc   = trace_port.jbtarget;  // target is the next pc of a jump.
  assign trace_jal   = trace_port.jal;
  assign trace_jalr  = trace_port.jr;        // register jump.

  osd_ctm #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_ctm (
    .clk         (clk),
    .reset       (reset),
    .id          (id),
    .debug_in    (debug_in),
    .debug_out   (debug_out),
    .trace_valid (trace_valid),
    .trace_pc    (trace_pc),
    .trace_npc   (trace_npc),
    .trace_jal   (trace_jal),
    .trace_jalr  (trace_jalr)
  );

endmodule

/* verilog/trace_event_fifo.sv */
//##########################################################################
// trace event queue
// circular buffer of trace events with a saturating count of the events
// dropped while the buffer was full.
//##########################################################################

module trace_event_fifo
  import dbg_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         wr_en,
  input  trace_event_t wr_event,
  input  logic         rd_en,
  output trace_event_t rd_event,
  output logic         empty,
  output logic [15:0]  drop_count,
  input  logic         drop_clear
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  trace_event_t     mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // entries held.
  logic             full;
  logic             do_wr;
  logic             do_rd;
  logic             drop;    // write lost to a full queue.

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full     = (count == CNT_W'(FIFO_DEPTH));
  assign empty    = (count == '0);
  assign do_wr    = wr_en && !full;
  assign drop     = wr_en && full;
  assign do_rd    = rd_en && !empty;
  assign rd_event = mem[rd_ptr];  // head entry, valid when not empty.

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_event;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
      if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither, level unchanged.
      endcase
    end
  end

  // a drop on the clearing edge starts the next count at one.
  always_ff @(posedge clk) begin
    if (reset) begin
      drop_count <= '0;
    end else if (drop_clear) begin
      drop_count <= drop ? 16'd1 : 16'd0;
    end else if (drop && (drop_count != 16'hffff)) begin
      drop_count <= drop_count + 16'd1;
    end
  end

  a_no_read_empty: assert property (@(posedge clk) disable iff (reset) rd_en |-> !empty)
    else $error("event queue read while empty.");

  a_drop_stable: assert property (@(posedge clk) disable iff (reset)
    !drop && !drop_clear |=> $stable(drop_count))
    else $error("drop count moved without a drop.");

endmodule

/* verilog/trace_packetizer.sv */
//##########################################################################
// trace packetizer
// pops queued events and sends them as seven-flit trace packets; pending
// drops are reported first in a four-flit overflow packet.
//##########################################################################

module trace_packetizer
  import dbg_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic [15:0]  id,
  input  logic [15:0]  event_dest,
  input  logic         ev_empty,
  input  trace_event_t ev,
  output logic         ev_pop,
  input  logic [15:0]  drop_count,
  output logic         drop_clear,
  dii_if.sender        debug_out
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_OVF,
    S_EVT
  } state_t;

  state_t       state_q;
  logic [2:0]   idx_q;     // index of the flit held in flit_q.
  logic [2:0]   nxt_idx;
  trace_event_t ev_q;      // event being sent.
  dii_flit_t    flit_q;    // registered output flit.
  dii_flit_t    nxt_flit;
  logic         advance;   // current flit is taken this cycle.

  assign advance = flit_q.valid && debug_out.ready;
  assign nxt_idx = idx_q + 3'd1;
  // overflow reports win over queued events.
  assign ev_pop  = (state_q == S_IDLE) && (drop_count == '0) && !ev_empty;
  // count is sampled into the last flit and cleared on the same edge.
  assign drop_clear = (state_q == S_OVF) && advance && (nxt_idx == 3'(OVF_PKT_LEN - 1));

  always_comb begin
    nxt_flit.valid = 1'b1;
    nxt_flit.data  = id;  // second flit of both packet kinds.
    if (state_q == S_OVF) begin
      nxt_flit.last = (nxt_idx == 3'(OVF_PKT_LEN - 1));
      case (nxt_idx)
        3'd2:    nxt_flit.data = TYPE_TRACE_OVERFLOW;
        3'd3:    nxt_flit.data = drop_count;
        default: ;
      endcase
    end else begin
      nxt_flit.last = (nxt_idx == 3'(TRACE_PKT_LEN - 1));
      case (nxt_idx)
        3'd2:    nxt_flit.data = TYPE_TRACE_EVENT | {15'd0, ev_q.kind};
        3'd3:    nxt_flit.data = ev_q.pc[31:16];
        3'd4:    nxt_flit.data = ev_q.pc[15:0];
        3'd5:    nxt_flit.data = ev_q.npc[31:16];
        3'd6:    nxt_flit.data = ev_q.npc[15:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ev_pop) begin
      ev_q <= ev;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q      <= S_IDLE;
      idx_q        <= '0;
      flit_q.valid <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (drop_count != '0) begin
            state_q <= S_OVF;
            idx_q   <= '0;
            flit_q  <= '{valid: 1'b1, last: 1'b0, data: event_dest};
          end else if (!ev_empty) begin
            state_q <= S_EVT;  // event popped this cycle.
            idx_q   <= '0;
            flit_q  <= '{valid: 1'b1, last: 1'b0, data: event_dest};
          end
        end
        default: begin
          if (advance) begin
            if (flit_q.last) begin
              state_q      <= S_IDLE;
              flit_q.valid <= 1'b0;
            end else begin
              idx_q  <= nxt_idx;
              flit_q <= nxt_flit;
            end
          end
        end
      endcase
    end
  end

  assign debug_out.valid = flit_q.valid;
  assign debug_out.last  = flit_q.last;
  assign debug_out.data  = flit_q.data;

  a_flit_hold: assert property (@(posedge clk) disable iff (reset)
    debug_out.valid && !debug_out.ready
    |=> $stable({debug_out.valid, debug_out.last, debug_out.data}))
    else $error("outgoing flit changed while stalled.");

endmodule
